// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: build.f
design/lc3b_pkg.sv
design/cc_unit.sv
design/mem_access_controller.sv
design/mem_lane_steer.sv
design/stage_mem.sv
design/line_memory.sv
design/mem_subsystem_top.sv
sim/tb_mem_subsystem.sv

// File: design/cc_unit.sv
`timescale 1ns/1ps

module cc_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  lc3b_pkg::lc3b_cc_src cc_src,
    input  logic                 cc_load,
    input  logic                 br_en_load,
    input  lc3b_pkg::lc3b_word   pcn_in,
    input  lc3b_pkg::lc3b_word   alu_in,
    input  lc3b_pkg::lc3b_word   mdr_in,
    input  lc3b_pkg::lc3b_word   sr2_in,
    input  lc3b_pkg::lc3b_cc     nzp,
    output logic                 br_en
);
    import lc3b_pkg::*;

    lc3b_word cc_val;
    lc3b_cc   cc_gen;
    lc3b_cc   cc_q;

    always_comb begin
        case (cc_src)
            cc_pcn:  cc_val = pcn_in;
            cc_mdr:  cc_val = mdr_in;
            cc_sr2:  cc_val = sr2_in;
            default: cc_val = alu_in;
        endcase

        // classify as two's complement value
        if (cc_val[word_width-1]) begin
            cc_gen = 3'b100;
        end else if (cc_val == '0) begin
            cc_gen = 3'b010;
        end else begin
            cc_gen = 3'b001;
        end
    end

    // br_en compares against the cc held before this instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            cc_q  <= 3'b010;
            br_en <= 1'b0;
        end else if (!stall) begin
            if (cc_load) begin
                cc_q <= cc_gen;
            end
            if (br_en_load) begin
                br_en <= |(nzp & cc_q);
            end
        end
    end

endmodule

// File: design/lc3b_pkg.sv
package lc3b_pkg;

    // datapath and memory line geometry
    localparam int word_width      = 16;
    localparam int line_width      = 128;
    localparam int line_words      = line_width / word_width;
    localparam int sel_width       = line_width / 8;
    localparam int line_addr_width = 12;

    typedef logic [word_width-1:0]      lc3b_word;
    typedef logic [line_width-1:0]      lc3b_line;
    typedef logic [sel_width-1:0]       lc3b_sel;
    typedef logic [line_addr_width-1:0] lc3b_line_addr;

    // n, z, p from msb to lsb
    typedef logic [2:0] lc3b_cc;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldw  = 4'b0110,
        op_stw  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // where the new condition codes come from
    typedef enum logic [1:0] {
        cc_pcn = 2'b00,
        cc_alu = 2'b01,
        cc_mdr = 2'b10,
        cc_sr2 = 2'b11
    } lc3b_cc_src;

    // data address source, 2'b11 is unused
    typedef enum logic [1:0] {
        addr_trapvect = 2'b00,
        addr_alu      = 2'b01,
        addr_indirect = 2'b10
    } lc3b_addr_src;

endpackage

// File: design/line_memory.sv
`timescale 1ns/1ps

module line_memory #(
    parameter int mem_latency  = 2,
    parameter int retry_period = 5,
    parameter int line_count   = 256
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cyc,
    input  logic                    stb,
    input  logic                    we,
    input  lc3b_pkg::lc3b_line_addr adr,
    input  lc3b_pkg::lc3b_sel       sel,
    input  lc3b_pkg::lc3b_line      dat_m,
    output logic                    ack,
    output logic                    rty,
    output lc3b_pkg::lc3b_line      dat_s
);
    import lc3b_pkg::*;

    localparam int idx_w = (line_count > 1) ? $clog2(line_count) : 1;

    lc3b_line         mem [line_count];
    logic [idx_w-1:0] idx;
    logic [7:0]       lat_cnt;
    // completed accesses since the last retry slot
    logic [7:0]       acc_cnt;
    logic             retried;
    logic             req;
    logic             answer;
    logic             rty_due;

    assign req     = cyc && stb;
    assign idx     = adr[idx_w-1:0];
    assign answer  = req && (lat_cnt == 8'(mem_latency));
    // a retry_period of 0 never retries
    assign rty_due = (retry_period > 0) && (acc_cnt == 8'(retry_period - 1)) && !retried;
    assign ack     = answer && !rty_due;
    assign rty     = answer && rty_due;
    assign dat_s   = mem[idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            lat_cnt <= '0;
            acc_cnt <= '0;
            retried <= 1'b0;
        end else begin
            // count strobe cycles per request
            if (!req || answer) begin
                lat_cnt <= '0;
            end else begin
                lat_cnt <= lat_cnt + 8'd1;
            end
            if (rty) begin
                retried <= 1'b1;
            end
            if (ack) begin
                retried <= 1'b0;
                if (acc_cnt == 8'(retry_period - 1)) begin
                    acc_cnt <= '0;
                end else begin
                    acc_cnt <= acc_cnt + 8'd1;
                end
            end
        end
    end

    // byte masked write, committed on ack only
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < line_count; i++) begin
                mem[i] <= '0;
            end
        end else if (ack && we) begin
            for (int b = 0; b < sel_width; b++) begin
                if (sel[b]) begin
                    mem[idx][b*8 +: 8] <= dat_m[b*8 +: 8];
                end
            end
        end
    end

endmodule

// File: design/mem_access_controller.sv
`timescale 1ns/1ps

module mem_access_controller (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  lc3b_pkg::lc3b_opcode   opcode,
    input  logic                   ack,
    input  logic                   rty,
    output lc3b_pkg::lc3b_addr_src addr_src,
    output logic                   word_access,
    output logic                   we,
    output logic                   stb,
    output logic                   mdr_load,
    output logic                   request_stall
);
    import lc3b_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_access,
        st_indirect_fetch,
        st_gap,
        st_final_access,
        st_done
    } state_t;

    state_t state;
    state_t state_next;
    // pointer already fetched, so a gap leads to the final access
    logic   second;
    logic   second_next;
    logic   is_mem;
    logic   is_ind;
    logic   is_byte;
    logic   is_store;
    logic   fetch_phase;
    logic   final_phase;
    logic   busy;

    always_comb begin
        is_ind   = (opcode == op_ldi) || (opcode == op_sti);
        is_byte  = (opcode == op_ldb) || (opcode == op_stb);
        is_store = (opcode == op_stb) || (opcode == op_stw) || (opcode == op_sti);
        is_mem   = is_ind || is_byte || (opcode == op_ldw) || (opcode == op_stw)
                   || (opcode == op_trap);
    end

    // idle doubles as the first strobe cycle of a new instruction
    always_comb begin
        stb         = 1'b0;
        fetch_phase = 1'b0;
        final_phase = 1'b0;
        addr_src    = (opcode == op_trap) ? addr_trapvect : addr_alu;
        case (state)
            st_idle: begin
                stb         = is_mem;
                fetch_phase = is_ind;
                final_phase = !is_ind;
            end
            st_access: begin
                stb         = 1'b1;
                final_phase = 1'b1;
            end
            st_indirect_fetch: begin
                stb         = 1'b1;
                fetch_phase = 1'b1;
            end
            st_final_access: begin
                stb         = 1'b1;
                final_phase = 1'b1;
                addr_src    = addr_indirect;
            end
            default: begin
            end
        endcase

        // pointer fetch is always a full word
        word_access = fetch_phase || !is_byte;
        we          = stb && is_store && !fetch_phase;
        mdr_load    = stb && fetch_phase;

        busy = (state != st_done) && !((state == st_idle) && !is_mem);
        request_stall = busy && !(ack && final_phase);
    end

    always_comb begin
        state_next  = state;
        second_next = second;
        case (state)
            st_idle, st_access, st_indirect_fetch, st_final_access: begin
                if (stb && rty) begin
                    // drop strobe one cycle, then re-issue
                    state_next = st_gap;
                end else if (stb && ack) begin
                    if (fetch_phase) begin
                        state_next  = st_gap;
                        second_next = 1'b1;
                    end else begin
                        state_next  = stall ? st_done : st_idle;
                        second_next = 1'b0;
                    end
                end else if (state == st_idle && is_mem) begin
                    state_next = is_ind ? st_indirect_fetch : st_access;
                end
            end
            st_gap: begin
                if (second) begin
                    state_next = st_final_access;
                end else if (is_ind) begin
                    state_next = st_indirect_fetch;
                end else begin
                    state_next = st_access;
                end
            end
            st_done: begin
                if (!stall) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= st_idle;
            second <= 1'b0;
        end else begin
            state  <= state_next;
            second <= second_next;
        end
    end

endmodule

// File: design/mem_lane_steer.sv
`timescale 1ns/1ps

module mem_lane_steer (
    input  lc3b_pkg::lc3b_word addr,
    input  logic               word_access,
    input  lc3b_pkg::lc3b_word sr2_in,
    input  lc3b_pkg::lc3b_line dat_s,
    output lc3b_pkg::lc3b_sel  sel,
    output lc3b_pkg::lc3b_line dat_m,
    output lc3b_pkg::lc3b_word load_data
);

    logic [2:0] word_idx;
    logic [3:0] byte_idx;

    // word slot in the line and byte slot with the odd bit
    assign word_idx = addr[3:1];
    assign byte_idx = addr[3:0];

    // byte selects
    always_comb begin
        sel = '0;
        if (word_access) begin
            sel[word_idx*2 +: 2] = 2'b11;
        end else begin
            sel[byte_idx] = 1'b1;
        end
    end

    // store data into its lane with the other lanes at zero
    always_comb begin
        dat_m = '0;
        if (word_access) begin
            dat_m[word_idx*16 +: 16] = sr2_in;
        end else begin
            dat_m[byte_idx*8 +: 8] = sr2_in[7:0];
        end
    end

    // byte loads are zero extended
    always_comb begin
        if (word_access) begin
            load_data = dat_s[word_idx*16 +: 16];
        end else begin
            load_data = {8'h00, dat_s[byte_idx*8 +: 8]};
        end
    end

endmodule

// File: design/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top #(
    parameter int mem_latency  = 2,
    parameter int retry_period = 5,
    parameter int line_count   = 256
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  lc3b_pkg::lc3b_opcode opcode,
    input  lc3b_pkg::lc3b_cc_src cc_src,
    input  logic                 cc_load,
    input  logic                 br_en_load,
    input  lc3b_pkg::lc3b_word   alu_in,
    input  lc3b_pkg::lc3b_word   ir_in,
    input  lc3b_pkg::lc3b_word   pcn_in,
    input  lc3b_pkg::lc3b_word   sr2_in,
    output lc3b_pkg::lc3b_word   mdr_out,
    output logic                 br_en,
    output logic                 request_stall
);
    import lc3b_pkg::*;

    logic          stage_stall;
    logic          cyc;
    logic          stb;
    logic          we;
    logic          ack;
    logic          rty;
    lc3b_line_addr adr;
    lc3b_sel       sel;
    lc3b_line      dat_m;
    lc3b_line      dat_s;

    // stage holds for either the pipeline or its own access
    assign stage_stall = stall | request_stall;

    stage_mem u_stage (
        .clk           (clk),
        .rst           (rst),
        .stall         (stage_stall),
        .opcode        (opcode),
        .cc_src        (cc_src),
        .cc_load       (cc_load),
        .br_en_load    (br_en_load),
        .alu_in        (alu_in),
        .ir_in         (ir_in),
        .pcn_in        (pcn_in),
        .sr2_in        (sr2_in),
        .cyc           (cyc),
        .stb           (stb),
        .we            (we),
        .adr           (adr),
        .sel           (sel),
        .dat_m         (dat_m),
        .ack           (ack),
        .rty           (rty),
        .dat_s         (dat_s),
        .mdr_out       (mdr_out),
        .br_en         (br_en),
        .request_stall (request_stall)
    );

    line_memory #(
        .mem_latency  (mem_latency),
        .retry_period (retry_period),
        .line_count   (line_count)
    ) u_mem (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .sel   (sel),
        .dat_m (dat_m),
        .ack   (ack),
        .rty   (rty),
        .dat_s (dat_s)
    );

endmodule

// File: design/stage_mem.sv
`timescale 1ns/1ps

module stage_mem (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  lc3b_pkg::lc3b_opcode    opcode,
    input  lc3b_pkg::lc3b_cc_src    cc_src,
    input  logic                    cc_load,
    input  logic                    br_en_load,
    input  lc3b_pkg::lc3b_word      alu_in,
    input  lc3b_pkg::lc3b_word      ir_in,
    input  lc3b_pkg::lc3b_word      pcn_in,
    input  lc3b_pkg::lc3b_word      sr2_in,
    output logic                    cyc,
    output logic                    stb,
    output logic                    we,
    output lc3b_pkg::lc3b_line_addr adr,
    output lc3b_pkg::lc3b_sel       sel,
    output lc3b_pkg::lc3b_line      dat_m,
    input  logic                    ack,
    input  logic                    rty,
    input  lc3b_pkg::lc3b_line      dat_s,
    output lc3b_pkg::lc3b_word      mdr_out,
    output logic                    br_en,
    output logic                    request_stall
);
    import lc3b_pkg::*;

    lc3b_addr_src addr_src;
    lc3b_word     trapvect8;
    lc3b_word     mem_addr;
    lc3b_word     load_data;
    lc3b_word     internal_mdr;
    lc3b_word     mdr_hold;
    logic         word_access;
    logic         mdr_load;

    assign trapvect8 = {7'b0, ir_in[7:0], 1'b0};

    always_comb begin
        case (addr_src)
            addr_trapvect: mem_addr = trapvect8;
            addr_indirect: mem_addr = internal_mdr;
            default:       mem_addr = alu_in;
        endcase
    end

    assign adr = mem_addr[15:4];
    assign cyc = stb;

    // read data is only valid in the ack cycle, so keep a copy
    assign mdr_out = (ack && !we) ? load_data : mdr_hold;

    always_ff @(posedge clk) begin
        if (ack && !we) begin
            mdr_hold <= load_data;
        end
        // pointer for ldi and sti
        if (mdr_load && ack) begin
            internal_mdr <= load_data;
        end
    end

    cc_unit u_cc_unit (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .cc_src     (cc_src),
        .cc_load    (cc_load),
        .br_en_load (br_en_load),
        .pcn_in     (pcn_in),
        .alu_in     (alu_in),
        .mdr_in     (mdr_out),
        .sr2_in     (sr2_in),
        .nzp        (ir_in[11:9]),
        .br_en      (br_en)
    );

    mem_access_controller u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .opcode        (opcode),
        .ack           (ack),
        .rty           (rty),
        .addr_src      (addr_src),
        .word_access   (word_access),
        .we            (we),
        .stb           (stb),
        .mdr_load      (mdr_load),
        .request_stall (request_stall)
    );

    mem_lane_steer u_steer (
        .addr        (mem_addr),
        .word_access (word_access),
        .sr2_in      (sr2_in),
        .dat_s       (dat_s),
        .sel         (sel),
        .dat_m       (dat_m),
        .load_data   (load_data)
    );

endmodule

// File: sim/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;
    import lc3b_pkg::*;

    localparam int mem_latency   = 2;
    localparam int retry_period  = 5;
    localparam int line_count    = 256;
    localparam int clk_period    = 20;
    localparam int reset_cycles  = 8;
    localparam int n_pairs       = 16;
    localparam int n_byte        = 8;
    localparam int n_ind         = 6;
    localparam int n_trap        = 8;
    localparam int max_stall_run = 3;
    // instructions over all tests with the stalled rerun and reset probes
    localparam int instr_count   = 4*n_pairs + 9*n_byte + 10*n_ind + 2*n_trap + 111 + 3;
    // two accesses each retried at most once plus a stall tail
    localparam int instr_cycles  = 2 * (2 * (mem_latency + 1) + 1) + max_stall_run + 4;
    localparam int timeout_ns    = (reset_cycles + 2 * instr_count * instr_cycles) * clk_period;

    logic       clk;
    logic       rst;
    logic       stall;
    lc3b_opcode opcode;
    lc3b_cc_src cc_src;
    logic       cc_load;
    logic       br_en_load;
    lc3b_word   alu_in;
    lc3b_word   ir_in;
    lc3b_word   pcn_in;
    lc3b_word   sr2_in;
    lc3b_word   mdr_out;
    logic       br_en;
    logic       request_stall;

    // word image of the data memory
    lc3b_word    ref_mem [line_count*8];
    logic [31:0] lfsr_q;
    int          errors      = 0;
    int          checks      = 0;
    int          write_total = 0;
    int          rty_total   = 0;
    int          stall_total = 0;
    // position of the next access within the retry period
    int          access_slot = 0;
    logic        retired     = 1'b0;
    logic        stall_mode;
    int          stall_run;
    lc3b_word    mdr_seen;
    logic        br_en_seen;
    lc3b_cc      exp_cc;

    mem_subsystem_top #(
        .mem_latency  (mem_latency),
        .retry_period (retry_period),
        .line_count   (line_count)
    ) UUT (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .opcode        (opcode),
        .cc_src        (cc_src),
        .cc_load       (cc_load),
        .br_en_load    (br_en_load),
        .alu_in        (alu_in),
        .ir_in         (ir_in),
        .pcn_in        (pcn_in),
        .sr2_in        (sr2_in),
        .mdr_out       (mdr_out),
        .br_en         (br_en),
        .request_stall (request_stall)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // retire edge tracking and bus event counts
    always @(posedge clk) begin
        retired <= !rst && !stall && !request_stall;
        if (UUT.ack && UUT.we) begin
            write_total <= write_total + 1;
        end
        if (UUT.rty) begin
            rty_total <= rty_total + 1;
        end
        if (request_stall) begin
            stall_total <= stall_total + 1;
        end
    end

    // strobe drops for one cycle after a retry
    assert property (@(posedge clk) disable iff (rst) UUT.rty |=> !UUT.stb)
    else begin
        errors++;
        $display("bus error at %0t: strobe stayed high right after rty", $time);
    end

    // a request holds until the memory answers it
    assert property (@(posedge clk) disable iff (rst)
        (UUT.stb && !UUT.ack && !UUT.rty) |=>
        (UUT.stb && $stable(UUT.adr) && $stable(UUT.we)))
    else begin
        errors++;
        $display("bus error at %0t: request changed before the memory answered", $time);
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hd000_0001;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic lc3b_word random_word();
        return 16'(random_bits(16));
    endfunction

    // byte address of slot 0 in a random line
    function automatic lc3b_word random_line_base();
        return 16'((random_bits(16) % line_count) * 16);
    endfunction

    function automatic lc3b_cc classify(input lc3b_word v);
        if (v[15]) begin
            return 3'b100;
        end
        if (v == 16'h0000) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    // bus accesses of one opcode including the pointer fetch
    function automatic int bus_accesses(input lc3b_opcode op);
        case (op)
            op_ldi, op_sti: return 2;
            op_ldb, op_ldw, op_stb, op_stw, op_trap: return 1;
            default: return 0;
        endcase
    endfunction

    function automatic int word_index(input lc3b_word a);
        return int'(a >> 1) % (line_count * 8);
    endfunction

    function automatic lc3b_word ref_load(input lc3b_word a, input logic byte_load);
        lc3b_word w;
        w = ref_mem[word_index(a)];
        if (!byte_load) begin
            return w;
        end
        if (a[0]) begin
            return {8'h00, w[15:8]};
        end
        return {8'h00, w[7:0]};
    endfunction

    task automatic ref_store(input lc3b_word a, input lc3b_word d, input logic byte_store);
        if (!byte_store) begin
            ref_mem[word_index(a)] = d;
        end else if (a[0]) begin
            ref_mem[word_index(a)][15:8] = d[7:0];
        end else begin
            ref_mem[word_index(a)][7:0] = d[7:0];
        end
    endtask

    task automatic check_value(input lc3b_word got, input lc3b_word exp, input string what);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic drive_stall();
        if (!stall_mode || stall_run >= max_stall_run) begin
            stall     = 1'b0;
            stall_run = 0;
        end else begin
            stall = (random_bits(1) != 0);
            if (stall) begin
                stall_run++;
            end else begin
                stall_run = 0;
            end
        end
    endtask

    // present one instruction and wait for its retire edge
    task automatic execute(input lc3b_opcode op, input lc3b_word alu, input lc3b_word ir,
                           input lc3b_word sr2);
        int   start_writes;
        int   start_rtys;
        int   start_stalls;
        int   accesses;
        int   exp_rtys;
        int   exp_stalls;
        logic done;
        logic is_store;
        start_writes = write_total;
        start_rtys   = rty_total;
        start_stalls = stall_total;
        is_store     = (op == op_stb) || (op == op_stw) || (op == op_sti);
        accesses     = bus_accesses(op);
        exp_rtys     = 0;
        // every retry_period-th access is answered once with rty
        for (int a = 0; a < accesses; a++) begin
            if (retry_period > 0) begin
                if (access_slot == retry_period - 1) begin
                    exp_rtys++;
                end
                access_slot = (access_slot + 1) % retry_period;
            end
        end
        // a retry adds the rty cycle, one idle cycle and the reissue
        exp_stalls = accesses * mem_latency + exp_rtys * (mem_latency + 2);
        if (accesses > 1) begin
            // pointer ack cycle plus the idle cycle before the final access
            exp_stalls += 2;
        end
        opcode       = op;
        alu_in       = alu;
        ir_in        = ir;
        sr2_in       = sr2;
        drive_stall();
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = retired;
            if (!done) begin
                drive_stall();
            end
        end
        mdr_seen   = mdr_out;
        br_en_seen = br_en;
        check_value(16'(write_total - start_writes), is_store ? 16'd1 : 16'd0,
                    "bus writes for one instruction");
        check_value(16'(rty_total - start_rtys), 16'(exp_rtys),
                    "retries for one instruction");
        check_value(16'(stall_total - start_stalls), 16'(exp_stalls),
                    "request_stall cycles for one instruction");
        // park on a non-memory opcode
        stall      = 1'b0;
        stall_run  = 0;
        opcode     = op_add;
        cc_load    = 1'b0;
        br_en_load = 1'b0;
    endtask

    task automatic do_store(input lc3b_opcode op, input lc3b_word a, input lc3b_word d);
        execute(op, a, 16'h0000, d);
        ref_store(a, d, op == op_stb);
    endtask

    task automatic do_load(input lc3b_opcode op, input lc3b_word a, input string what);
        execute(op, a, 16'h0000, random_word());
        check_value(mdr_seen, ref_load(a, op == op_ldb), what);
    endtask

    task automatic word_test();
        lc3b_word addrs [n_pairs];
        for (int i = 0; i < n_pairs; i++) begin
            addrs[i] = random_line_base() | {12'h000, 3'(i), 1'b0};
            do_store(op_stw, addrs[i], random_word());
        end
        for (int i = 0; i < n_pairs; i++) begin
            do_load(op_ldw, addrs[i], "ldw after stw");
        end
    endtask

    task automatic byte_test();
        lc3b_word base;
        for (int i = 0; i < n_byte; i++) begin
            // even slot so the neighbour word sits in the same line
            base = random_line_base() | 16'(random_bits(2) << 2);
            do_store(op_stw, base, random_word());
            do_store(op_stw, base + 16'd2, random_word());
            do_store(op_stb, base | 16'h0001, random_word());
            do_load(op_ldw, base, "word after stb to high byte");
            do_load(op_ldw, base + 16'd2, "neighbour word after stb");
            do_store(op_stb, base + 16'd2, random_word());
            do_load(op_ldw, base + 16'd2, "word after stb to low byte");
            do_load(op_ldb, base | 16'h0001, "ldb of high byte");
            do_load(op_ldb, base + 16'd2, "ldb of low byte");
        end
    endtask

    task automatic indirect_test();
        lc3b_word ptr_loc;
        lc3b_word target;
        lc3b_word d;
        for (int i = 0; i < n_ind; i++) begin
            ptr_loc = random_line_base() | 16'(random_bits(3) << 1);
            // pointed-to word lives in the other half of the memory
            target  = 16'((int'(ptr_loc) + line_count * 8) % (line_count * 16));
            do_store(op_stw, ptr_loc, target);
            do_store(op_stw, target, random_word());
            execute(op_ldi, ptr_loc, 16'h0000, random_word());
            check_value(mdr_seen, ref_load(ref_load(ptr_loc, 1'b0), 1'b0), "ldi data");
            d = random_word();
            execute(op_sti, ptr_loc, 16'h0000, d);
            ref_store(ref_load(ptr_loc, 1'b0), d, 1'b0);
            do_load(op_ldw, target, "word written by sti");
        end
    endtask

    task automatic trap_test();
        lc3b_word vec;
        for (int i = 0; i < n_trap; i++) begin
            vec = 16'(random_bits(8));
            do_store(op_stw, vec << 1, random_word());
            execute(op_trap, random_word(), {8'hf0, vec[7:0]}, random_word());
            check_value(mdr_seen, ref_load(vec << 1, 1'b0), "trap vector word");
        end
    endtask

    task automatic cc_test();
        lc3b_word value;
        lc3b_word addr;
        for (int s = 0; s < 4; s++) begin
            for (int k = 0; k < 3; k++) begin
                value = random_word();
                if (k == 0) begin
                    value[15] = 1'b1;
                end else if (k == 1) begin
                    value = 16'h0000;
                end else begin
                    value[15] = 1'b0;
                    if (value == 16'h0000) begin
                        value = 16'h0001;
                    end
                end
                cc_src = lc3b_cc_src'(s);
                pcn_in = (cc_src == cc_pcn) ? value : random_word();
                if (cc_src == cc_mdr) begin
                    addr = random_line_base();
                    do_store(op_stw, addr, value);
                    cc_load = 1'b1;
                    execute(op_ldw, addr, 16'h0000, random_word());
                end else begin
                    cc_load = 1'b1;
                    execute(op_add, (cc_src == cc_alu) ? value : random_word(), 16'h0000,
                            (cc_src == cc_sr2) ? value : random_word());
                end
                exp_cc = classify(value);
                for (int m = 0; m < 8; m++) begin
                    br_en_load = 1'b1;
                    execute(op_br, random_word(), {4'h0, 3'(m), 9'h000}, random_word());
                    check_value(16'(br_en_seen), 16'(|(3'(m) & exp_cc)), "br_en for nzp mask");
                end
            end
        end
    endtask

    initial begin
        #(timeout_ns);
        $display("watchdog expired after %0d ns, an instruction never retired", timeout_ns);
        $display("checks: %0d errors: %0d", checks, errors);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        stall      = 1'b0;
        opcode     = op_add;
        cc_src     = cc_alu;
        cc_load    = 1'b0;
        br_en_load = 1'b0;
        alu_in     = 16'h0000;
        ir_in      = 16'h0000;
        pcn_in     = 16'h0000;
        sr2_in     = 16'h0000;
        lfsr_q     = 32'h2d66_d374;
        stall_mode = 1'b0;
        stall_run  = 0;
        exp_cc     = 3'b010;
        for (int i = 0; i < line_count * 8; i++) begin
            ref_mem[i] = 16'h0000;
        end
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        check_value(16'({UUT.cyc, UUT.stb, UUT.we, request_stall}), 16'h0000,
                    "bus and stall idle in reset");
        check_value(16'(br_en), 16'h0000, "br_en in reset");
        rst = 1'b0;

        // cc comes out of reset as z
        br_en_load = 1'b1;
        execute(op_br, 16'h0000, {4'h0, 3'b010, 9'h000}, 16'h0000);
        check_value(16'(br_en_seen), 16'h0001, "br_en on z mask after reset");
        br_en_load = 1'b1;
        execute(op_br, 16'h0000, {4'h0, 3'b101, 9'h000}, 16'h0000);
        check_value(16'(br_en_seen), 16'h0000, "br_en on n and p mask after reset");

        // memory comes out of reset cleared
        do_load(op_ldw, random_line_base() | 16'(random_bits(3) << 1),
                "memory word after reset");

        word_test();
        byte_test();
        indirect_test();
        trap_test();
        cc_test();

        // same traffic again with the pipeline stalling at random
        stall_mode = 1'b1;
        word_test();
        indirect_test();

        checks++;
        assert (rty_total > 0)
        else begin
            errors++;
            $display("no retry was seen on the bus during the whole run");
        end

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
